//--- hdl/chmux_macros.svh
//##########################################################
// chmux sizing macros.
// channel counts, sample width and the widths derived from
// them, shared by the package and the RTL.
//##########################################################
`ifndef CHMUX_MACROS_SVH
`define CHMUX_MACROS_SVH

// sample format.
`define CHMUX_SAMPLE_WIDTH      16
`define CHMUX_PARALLEL_SAMPLES  4
`define CHMUX_DATA_WIDTH        (`CHMUX_SAMPLE_WIDTH * `CHMUX_PARALLEL_SAMPLES)

// channel counts.
`define CHMUX_INPUT_CHANNELS    8
`define CHMUX_OUTPUT_CHANNELS   4
`define CHMUX_SELECT_BITS       3  // covers all input channels.

// mode bit plus one select field per output.
`define CHMUX_CONFIG_WIDTH      (1 + `CHMUX_OUTPUT_CHANNELS * `CHMUX_SELECT_BITS)

`endif

//--- hdl/chmux_pkg.sv
//##########################################################
// chmux types.
// channel banks, routing state and the configuration word
// with its map and broadcast views.
//##########################################################
`include "chmux_macros.svh"

package chmux_pkg;

  typedef logic [`CHMUX_DATA_WIDTH-1:0]  chan_data_t;  // one parallel word.
  typedef logic [`CHMUX_SELECT_BITS-1:0] select_t;

  // full set of input channels, 520 bits.
  typedef struct packed {
    chan_data_t [`CHMUX_INPUT_CHANNELS-1:0] data;
    logic       [`CHMUX_INPUT_CHANNELS-1:0] valid;
  } in_bank_t;

  // full set of output channels, 260 bits.
  typedef struct packed {
    chan_data_t [`CHMUX_OUTPUT_CHANNELS-1:0] data;
    logic       [`CHMUX_OUTPUT_CHANNELS-1:0] valid;
  } out_bank_t;

  typedef enum logic {
    CFG_MAP       = 1'b0,
    CFG_BROADCAST = 1'b1
  } cfg_mode_e;

  typedef struct packed {
    cfg_mode_e                               mode;
    select_t [`CHMUX_OUTPUT_CHANNELS-1:0]    src;  // one source per output.
  } cfg_map_t;

  typedef struct packed {
    cfg_mode_e                               mode;
    select_t                                 src;
    logic    [`CHMUX_OUTPUT_CHANNELS-1:0]    enable;
    logic    [`CHMUX_CONFIG_WIDTH-2-`CHMUX_SELECT_BITS-`CHMUX_OUTPUT_CHANNELS:0] reserved;
  } cfg_bcast_t;

  // mode bit sits at the top in both views.
  typedef union packed {
    cfg_map_t   map;
    cfg_bcast_t bcast;
  } cfg_word_u;

  typedef struct packed {
    select_t [`CHMUX_OUTPUT_CHANNELS-1:0] src;
    logic    [`CHMUX_OUTPUT_CHANNELS-1:0] enable;
  } route_t;

endpackage

//--- hdl/select_config.sv
//##########################################################
// select_config
// decodes configuration words in map or broadcast form and
// holds the active routing and output enable mask.
//##########################################################
`timescale 1ns/100ps
`include "chmux_macros.svh"

module select_config (
  input  logic                 clk,
  input  logic                 reset,
  input  chmux_pkg::cfg_word_u cfg_data,
  input  logic                 cfg_valid,
  output chmux_pkg::route_t    route
);

  import chmux_pkg::*;

  route_t route_next;

  // map view, every output names its own source.
  function automatic route_t decode_map(input cfg_map_t word);
    route_t r;
    for (int o = 0; o < `CHMUX_OUTPUT_CHANNELS; o++) begin
      r.src[o] = word.src[o];
    end
    r.enable = '1;  // all outputs live.
    return r;
  endfunction

  // broadcast view, one source fanned out under a mask.
  function automatic route_t decode_bcast(input cfg_bcast_t word);
    route_t r;
    for (int o = 0; o < `CHMUX_OUTPUT_CHANNELS; o++) begin
      r.src[o] = word.src;
    end
    r.enable = word.enable;
    return r;
  endfunction

  always_comb begin
    route_next = route;  // hold between strobes.
    if (cfg_valid) begin
      unique case (cfg_data.map.mode)
        CFG_MAP:       route_next = decode_map(cfg_data.map);
        CFG_BROADCAST: route_next = decode_bcast(cfg_data.bcast);
        default:       route_next = route;
      endcase
    end
  end

  // outputs stay dark until the first strobe.
  always_ff @(posedge clk) begin
    if (reset) begin
      route <= '0;
    end else begin
      route <= route_next;
    end
  end

  // an unknown strobe would leave the routing undefined
  // for every later cycle.
  a_cfg_valid_known: assert property (
    @(posedge clk) disable iff (reset)
    !$isunknown(cfg_valid)
  ) else $error("cfg_valid is unknown.");

endmodule

//--- hdl/channel_mux.sv
//##########################################################
// channel_mux
// one register stage that picks the routed input word and
// valid for each output, gated by the enable mask.
//##########################################################
`timescale 1ns/100ps
`include "chmux_macros.svh"

module channel_mux (
  input  logic                 clk,
  input  logic                 reset,
  input  chmux_pkg::in_bank_t  data_in,
  input  chmux_pkg::route_t    route,
  output chmux_pkg::out_bank_t data_out
);

  import chmux_pkg::*;

  chan_data_t [`CHMUX_OUTPUT_CHANNELS-1:0] sel_data;
  logic       [`CHMUX_OUTPUT_CHANNELS-1:0] sel_valid;  // ungated.

  always_comb begin
    for (int o = 0; o < `CHMUX_OUTPUT_CHANNELS; o++) begin
      sel_data[o]  = data_in.data[route.src[o]];
      sel_valid[o] = data_in.valid[route.src[o]];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      data_out <= '0;
    end else begin
      for (int o = 0; o < `CHMUX_OUTPUT_CHANNELS; o++) begin
        data_out.valid[o] <= sel_valid[o] & route.enable[o];
        // data tracks the source only on its valid cycles.
        if (sel_valid[o]) begin
          data_out.data[o] <= sel_data[o];
        end
      end
    end
  end

  for (genvar o = 0; o < `CHMUX_OUTPUT_CHANNELS; o++) begin : g_check

    // a masked output stays quiet on the following cycle.
    a_disabled_quiet: assert property (
      @(posedge clk) disable iff (reset)
      !route.enable[o] |=> !data_out.valid[o]
    ) else $error("output %0d valid while disabled.", o);

    // an enabled output mirrors the routed input valid one cycle later.
    a_valid_follows: assert property (
      @(posedge clk) disable iff (reset)
      route.enable[o] |=> data_out.valid[o] == $past(data_in.valid[route.src[o]])
    ) else $error("output %0d valid does not follow its source.", o);

  end

endmodule

//--- hdl/chmux_top.sv
//##########################################################
// chmux_top
// channel multiplexer top, config decoder feeding the
// registered output selection.
//##########################################################
`timescale 1ns/100ps

module chmux_top (
  input  logic                 clk,
  input  logic                 reset,
  input  chmux_pkg::in_bank_t  data_in,
  input  chmux_pkg::cfg_word_u cfg_data,
  input  logic                 cfg_valid,
  output chmux_pkg::out_bank_t data_out
);

  import chmux_pkg::*;

  route_t route;  // active routing, one cycle ahead of the data.

  select_config u_select_config (
    .clk       (clk),
    .reset     (reset),
    .cfg_data  (cfg_data),
    .cfg_valid (cfg_valid),
    .route     (route)
  );

  channel_mux u_channel_mux (
    .clk      (clk),
    .reset    (reset),
    .data_in  (data_in),
    .route    (route),
    .data_out (data_out)
  );

endmodule

//--- dv/chmux_checker.sv
//##########################################################
// chmux checker
// reference model of the routing and the output register,
// compared against the DUT on every falling edge.
//##########################################################
`timescale 1ns/100ps
`include "chmux_macros.svh"

module chmux_checker (
  input  logic                              clk,
  input  logic                              reset,
  input  chmux_pkg::in_bank_t               data_in,
  input  chmux_pkg::cfg_word_u              cfg_data,
  input  logic                              cfg_valid,
  input  chmux_pkg::out_bank_t              data_out,
  input  logic                              test_start,
  input  logic [`CHMUX_OUTPUT_CHANNELS-1:0] exp_mask,
  input  int                                test_id,
  output logic                              test_done,
  output int                                done_id,
  output int                                done_checks,
  output int                                done_errors,
  output int                                total_checks,
  output int                                total_errors
);

  import chmux_pkg::*;

  localparam int OUTS = `CHMUX_OUTPUT_CHANNELS;
  localparam int SB   = `CHMUX_SELECT_BITS;
  localparam int CW   = `CHMUX_CONFIG_WIDTH;

  logic [SB-1:0]                model_src [OUTS];
  logic [OUTS-1:0]              model_en;
  logic [`CHMUX_DATA_WIDTH-1:0] exp_data  [OUTS];
  logic [OUTS-1:0]              exp_valid;
  int                           exp_id;  // test that drove the data now at the outputs.
  int                           cur_id;
  bit                           armed;
  int                           checks_by_id [int];
  int                           errors_by_id [int];

  initial begin
    armed        = 1'b0;
    cur_id       = -1;
    exp_id       = -1;
    test_done    = 1'b0;
    done_id      = -1;
    done_checks  = 0;
    done_errors  = 0;
    total_checks = 0;
    total_errors = 0;
  end

  task automatic record(input int id, input bit ok);
    total_checks++;
    if (!ok) total_errors++;
    if (id >= 0) begin
      if (!checks_by_id.exists(id)) begin
        checks_by_id[id] = 0;
        errors_by_id[id] = 0;
      end
      checks_by_id[id]++;
      if (!ok) errors_by_id[id]++;
    end
  endtask

  // top bit picks the view; broadcast is src, then mask, then spare bits.
  task automatic decode_config(input logic [CW-1:0] word);
    if (word[CW-1]) begin
      for (int o = 0; o < OUTS; o++) model_src[o] = word[CW-2 -: SB];
      model_en = word[CW-2-SB -: OUTS];
    end else begin
      for (int o = 0; o < OUTS; o++) model_src[o] = word[o*SB +: SB];
      model_en = '1;
    end
  endtask

  always @(posedge clk) begin
    logic [SB-1:0] src;
    bit            ok;
    if (reset) begin
      for (int o = 0; o < OUTS; o++) begin
        model_src[o] = '0;
        exp_data[o]  = '0;
      end
      model_en  = '0;
      exp_valid = '0;
      exp_id    = -1;
      armed     = 1'b1;
    end else begin
      // register stage sees the routing from before this edge.
      for (int o = 0; o < OUTS; o++) begin
        src          = model_src[o];
        exp_valid[o] = data_in.valid[src] & model_en[o];
        if (data_in.valid[src]) exp_data[o] = data_in.data[src];
      end
      exp_id = test_id;
      if (cfg_valid) decode_config(cfg_data);
      if (test_start) begin
        ok = (model_en == exp_mask);
        record(test_id, ok);
        if (!ok) begin
          $display("[ERROR] %0t: test %0d enable mask is %b, expected %b",
                   $time, test_id, model_en, exp_mask);
        end
      end
    end
  end

  // outputs are settled half a cycle after the edge.
  always @(negedge clk) begin
    bit ok;
    test_done = 1'b0;
    if (armed) begin
      if (exp_id != cur_id) begin
        if (cur_id >= 0) begin
          done_id     = cur_id;
          done_checks = checks_by_id[cur_id];
          done_errors = errors_by_id[cur_id];
          test_done   = 1'b1;
        end
        cur_id = exp_id;
      end
      for (int o = 0; o < OUTS; o++) begin
        ok = (data_out.valid[o] === exp_valid[o]);
        record(exp_id, ok);
        if (!ok) begin
          $display("[ERROR] %0t: output %0d valid is %b, expected %b",
                   $time, o, data_out.valid[o], exp_valid[o]);
        end
        ok = (data_out.data[o] === exp_data[o]);
        record(exp_id, ok);
        if (!ok) begin
          $display("[ERROR] %0t: output %0d data is %h, expected %h",
                   $time, o, data_out.data[o], exp_data[o]);
        end
      end
    end
  end

endmodule

//--- dv/chmux_tb.sv
//##########################################################
// chmux testbench
// streams random channel data through the DUT under the
// routing words listed in the test file.
//##########################################################
`timescale 1ns/100ps
`include "chmux_macros.svh"

module chmux_tb;

  import chmux_pkg::*;

  localparam int PAT_ALL    = 0;
  localparam int PAT_RAND   = 1;
  localparam int PAT_IDLE   = 2;  // random data without a config strobe.
  localparam int RESET_LEN  = 16;
  localparam int FLUSH_LEN  = 4;
  localparam int MARGIN     = 40;

  logic      clk;
  logic      reset;
  in_bank_t  data_in;
  cfg_word_u cfg_data;
  logic      cfg_valid;
  out_bank_t data_out;

  logic                              test_start;
  logic [`CHMUX_OUTPUT_CHANNELS-1:0] exp_mask;
  int                                test_id;
  logic                              test_done;
  int                                done_id;
  int                                done_checks;
  int                                done_errors;
  int                                total_checks;
  int                                total_errors;

  string                             test_name    [$];
  logic [`CHMUX_CONFIG_WIDTH-1:0]    test_cfg     [$];
  int                                test_cycles  [$];
  int                                test_pattern [$];
  logic [`CHMUX_OUTPUT_CHANNELS-1:0] test_mask    [$];

  int reported       = 0;
  int failed_tests   = 0;
  int cycle_count    = 0;
  int timeout_cycles = 1000;
  bit load_ok;

  chmux_top DUT (
    .clk       (clk),
    .reset     (reset),
    .data_in   (data_in),
    .cfg_data  (cfg_data),
    .cfg_valid (cfg_valid),
    .data_out  (data_out)
  );

  chmux_checker u_checker (
    .clk          (clk),
    .reset        (reset),
    .data_in      (data_in),
    .cfg_data     (cfg_data),
    .cfg_valid    (cfg_valid),
    .data_out     (data_out),
    .test_start   (test_start),
    .exp_mask     (exp_mask),
    .test_id      (test_id),
    .test_done    (test_done),
    .done_id      (done_id),
    .done_checks  (done_checks),
    .done_errors  (done_errors),
    .total_checks (total_checks),
    .total_errors (total_errors)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic read_tests(output bit ok);
    int          fd;
    int          n;
    int          cycles;
    string       line;
    string       name;
    string       pat;
    logic [31:0] word;
    logic [31:0] mask;
    ok = 1'b1;
    fd = $fopen("dv/chmux_input.txt", "r");
    if (fd == 0) begin
      $display("could not open the test file dv/chmux_input.txt");
      ok = 1'b0;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%s %h %d %s %h", name, word, cycles, pat, mask);
          if (n == 5) begin
            test_name.push_back(name);
            test_cfg.push_back(word[`CHMUX_CONFIG_WIDTH-1:0]);
            test_cycles.push_back(cycles < 1 ? 1 : cycles);
            test_mask.push_back(mask[`CHMUX_OUTPUT_CHANNELS-1:0]);
            if (pat == "all") test_pattern.push_back(PAT_ALL);
            else if (pat == "rand") test_pattern.push_back(PAT_RAND);
            else if (pat == "idle") test_pattern.push_back(PAT_IDLE);
            else begin
              $display("unknown valid pattern %s for test %s", pat, name);
              ok = 1'b0;
            end
          end
        end
      end
      $fclose(fd);
      if (test_name.size() == 0) begin
        $display("the test file holds no tests");
        ok = 1'b0;
      end
    end
  endtask

  task automatic drive_data(input int pattern);
    logic [31:0] rnd;
    for (int ch = 0; ch < `CHMUX_INPUT_CHANNELS; ch++) begin
      data_in.data[ch] = {$urandom(), $urandom()};
    end
    rnd = $urandom();
    data_in.valid = (pattern == PAT_ALL) ? '1 : rnd[`CHMUX_INPUT_CHANNELS-1:0];
  endtask

  // config goes out with the first data cycle so streaming never pauses.
  task automatic run_test(input int idx);
    for (int c = 0; c < test_cycles[idx]; c++) begin
      @(negedge clk);
      drive_data(test_pattern[idx]);
      test_id = idx;
      if (c == 0) begin
        test_start = 1'b1;
        cfg_valid  = (test_pattern[idx] != PAT_IDLE);
        cfg_data   = test_cfg[idx];
        exp_mask   = test_mask[idx];
      end else begin
        test_start = 1'b0;
        cfg_valid  = 1'b0;
      end
    end
  endtask

  task automatic flush_outputs();
    repeat (FLUSH_LEN) begin
      @(negedge clk);
      data_in.valid = '0;
      cfg_valid     = 1'b0;
      test_start    = 1'b0;
      test_id       = -2;
    end
  endtask

  always @(posedge clk) begin
    if (test_done) begin
      $display("test %0s: %0d checks, %0d errors, %0s", test_name[done_id],
               done_checks, done_errors, (done_errors == 0) ? "ok" : "FAILED");
      reported++;
      if (done_errors != 0) failed_tests++;
    end
  end

  initial begin
    @(posedge clk);
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(19));
    reset      = 1'b1;
    data_in    = '0;
    cfg_data   = '0;
    cfg_valid  = 1'b0;
    test_start = 1'b0;
    exp_mask   = '0;
    test_id    = -1;
    read_tests(load_ok);
    if (!load_ok) begin
      $display("** FAIL **");
      $finish;
    end else begin
      timeout_cycles = RESET_LEN + FLUSH_LEN + MARGIN;
      foreach (test_cycles[i]) timeout_cycles += test_cycles[i];
      repeat (RESET_LEN) @(negedge clk);
      reset = 1'b0;
      for (int i = 0; i < test_name.size(); i++) run_test(i);
      flush_outputs();
      while (reported < test_name.size()) @(posedge clk);
      $display("tests %0d, failed %0d, checks %0d, errors %0d",
               test_name.size(), failed_tests, total_checks, total_errors);
      if (total_errors == 0 && failed_tests == 0) begin
        $display("** PASS **");
      end else begin
        $display("** FAIL **");
      end
      $finish;
    end
  end

endmodule

//--- vlog.f
+incdir+hdl
hdl/chmux_pkg.sv
hdl/select_config.sv
hdl/channel_mux.sv
hdl/chmux_top.sv
dv/chmux_checker.sv
dv/chmux_tb.sv

//--- Makefile
# Verilator flow for the channel multiplexer.
# Every variable can be overridden on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= chmux_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= ** PASS **

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -o V$(TOP)

# the verdict comes from the log, not from the simulator exit code.
sim: build
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qxF '$(PASS_MSG)' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- dv/chmux_input.txt
# columns: name  config_word(hex, 13 bits)  cycles  valid_pattern(all|rand|idle)  mask(hex)
# idle streams random data with no config strobe; mask is the enable mask expected after decode.
idle_after_reset   0000  20  idle  0
map_identity       0688  24  all   f
map_upper          0fac  24  rand  f
map_shared_src     056d  20  all   f
map_pairs          0d89  20  rand  f
bcast_all          17e0  20  all   f
bcast_partial      1ca0  20  all   5
bcast_none         1400  16  rand  0
bcast_reserved     1f5f  24  rand  a
rand_valid_map     08f8  32  rand  f
b2b_map_a          0688  1   rand  f
b2b_bcast_a        1ca0  1   all   5
b2b_map_b          0fac  2   all   f
b2b_bcast_b        17e0  1   rand  f
b2b_map_c          08f8  1   all   f
b2b_bcast_c        1f5f  1   rand  a
settle_shared      056d  12  rand  f
idle_keeps_route   0000  10  idle  f
bcast_final        19e0  20  rand  f
